/* rtl/tracker_cfg_pkg.sv */
`default_nettype none

package tracker_cfg_pkg;

  // Number of transaction tags that the freelist hands out
  localparam int num_entries = 8;

  // Allocation ports. Kept below half of num_entries so the two-deep
  // staging registers can never soak up every free tag at once
  localparam int num_alloc_ports = 2;

  // Width of a binary tag number
  localparam int tag_width = $clog2(num_entries);

  // The free count needs one extra code so that all-free fits
  localparam int count_width = $clog2(num_entries + 1);

  typedef logic [tag_width-1:0] tag_t;
  typedef logic [count_width-1:0] count_t;

  // One bit per tag, bit i stands for tag i
  typedef logic [num_entries-1:0] tag_vec_t;

endpackage

`default_nettype wire

/* rtl/tracker_msg_pkg.sv */
`default_nettype none

package tracker_msg_pkg;

  // Context word supplied by a requester when it takes a tag
  typedef struct packed {
    logic [15:0] data;
  } ctx_t;

  // A completion names only the tag that is being handed back
  typedef struct packed {
    tracker_cfg_pkg::tag_t tag;
  } cpl_req_t;

  // The completion response echoes the tag together with its stored context
  typedef struct packed {
    tracker_cfg_pkg::tag_t tag;
    ctx_t                  ctx;
  } cpl_rsp_t;

endpackage

`default_nettype wire

/* rtl/first_free_picker.sv */
`default_nettype none

module first_free_picker (
  input  tracker_cfg_pkg::tag_vec_t free_vec,
  output logic                      found,
  output tracker_cfg_pkg::tag_vec_t pick_onehot,
  output tracker_cfg_pkg::tag_t     pick_tag
);
  import tracker_cfg_pkg::*;

  // Lowest set bit wins, so tag 0 has the highest priority
  always_comb begin
    // Adding one to the inverse carries up to the first set bit, and the
    // AND keeps only that bit
    pick_onehot = free_vec & (~free_vec + tag_vec_t'(1));
    pick_tag = '0;
    for (int i = 0; i < num_entries; i++) begin
      // At most one bit survives above, so OR-ing the indices of the set
      // bits gives the binary tag directly
      if (pick_onehot[i]) begin
        pick_tag = pick_tag | tag_t'(i);
      end
    end
  end

  // Any free bit means the pick above is meaningful
  assign found = |free_vec;

endmodule

`default_nettype wire

/* rtl/flow_stage_reg.sv */
`default_nettype none

module flow_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push_valid,
  output logic     push_ready,
  input  payload_t push_data,
  output logic     pop_valid,
  input  logic     pop_ready,
  output payload_t pop_data
);

  // Main register drives the pop side directly
  logic     main_valid_q;
  logic     main_valid_d;
  payload_t main_data_q;
  payload_t main_data_d;

  // Skid register catches the item that arrives while the main one stalls
  logic     skid_valid_q;
  logic     skid_valid_d;
  payload_t skid_data_q;
  payload_t skid_data_d;

  logic push_ready_q;
  logic push_fire;
  logic pop_fire;

  assign push_fire = push_valid & push_ready_q;
  assign pop_fire = main_valid_q & pop_ready;

  always_comb begin
    main_valid_d = main_valid_q;
    main_data_d = main_data_q;
    skid_valid_d = skid_valid_q;
    skid_data_d = skid_data_q;
    if (!main_valid_q || pop_fire) begin
      // Main slot frees up, the older skid item goes first to keep order
      if (skid_valid_q) begin
        main_valid_d = 1'b1;
        main_data_d = skid_data_q;
        skid_valid_d = 1'b0;
      end else begin
        main_valid_d = push_fire;
        if (push_fire) begin
          main_data_d = push_data;
        end
      end
    end else if (push_fire) begin
      // Main is stalled, park the new item in the skid slot
      skid_valid_d = 1'b1;
      skid_data_d = push_data;
    end
  end

  // Control flops clear on reset; push_ready stays low for the first cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      push_ready_q <= 1'b0;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      // Ready to push as long as the skid slot will be empty
      push_ready_q <= !skid_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    main_data_q <= main_data_d;
    skid_data_q <= skid_data_d;
  end

  assign push_ready = push_ready_q;
  assign pop_valid = main_valid_q;
  assign pop_data = main_data_q;

endmodule

`default_nettype wire

/* rtl/tag_freelist.sv */
`default_nettype none

module tag_freelist (
  input  logic                                                       clk,
  input  logic                                                       rst_n,
  output logic [tracker_cfg_pkg::num_alloc_ports-1:0]                alloc_valid,
  input  logic [tracker_cfg_pkg::num_alloc_ports-1:0]                alloc_ready,
  output tracker_cfg_pkg::tag_t [tracker_cfg_pkg::num_alloc_ports-1:0] alloc_tag,
  input  logic                                                       dealloc_valid,
  input  tracker_cfg_pkg::tag_t                                      dealloc_tag
);
  import tracker_cfg_pkg::*;

  // Free tags that are neither staged nor held by a requester
  tag_vec_t free_vec_q;
  tag_vec_t free_vec_d;
  tag_vec_t dealloc_onehot;
  // Free vector with every tag pushed this cycle removed
  tag_vec_t unpicked;
  logic [num_alloc_ports-1:0] push_fire;
  logic free_le;

  for (genvar i = 0; i < num_alloc_ports; i++) begin : g_port
    // Tags this port may pick from, after lower ports have taken theirs
    tag_vec_t avail_in;
    tag_vec_t avail_out;
    tag_vec_t pick_onehot;
    tag_t     pick_tag;
    logic     found;
    logic     push_ready;

    // Port 0 sees the whole free vector and each later port sees what is left
    if (i == 0) begin : g_head
      assign avail_in = free_vec_q;
    end else begin : g_chain
      assign avail_in = g_port[i-1].avail_out;
    end

    first_free_picker u_picker (
      .free_vec    (avail_in),
      .found       (found),
      .pick_onehot (pick_onehot),
      .pick_tag    (pick_tag)
    );

    // Valid may drop without a transfer when a lower port takes the last tag
    assign push_fire[i] = found & push_ready;

    // Only a tag that actually moves into staging is masked for later ports
    assign avail_out = push_fire[i] ? (avail_in & ~pick_onehot) : avail_in;

    // Two-deep staging so a tag is ready every cycle under steady demand
    flow_stage_reg #(
      .payload_t (tag_t)
    ) u_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (found),
      .push_ready (push_ready),
      .push_data  (pick_tag),
      .pop_valid  (alloc_valid[i]),
      .pop_ready  (alloc_ready[i]),
      .pop_data   (alloc_tag[i])
    );
  end

  assign unpicked = g_port[num_alloc_ports-1].avail_out;

  // Returned tag goes straight back into the free vector
  assign dealloc_onehot = dealloc_valid ? (tag_vec_t'(1) << dealloc_tag) : '0;

  assign free_vec_d = unpicked | dealloc_onehot;

  // Vector only changes when something is staged or handed back
  assign free_le = (|push_fire) | dealloc_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Every tag starts free
      free_vec_q <= '1;
    end else if (free_le) begin
      free_vec_q <= free_vec_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/free_count.sv */
`default_nettype none

module free_count (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [tracker_cfg_pkg::num_alloc_ports-1:0] alloc_fire,
  input  logic                                        dealloc_fire,
  output tracker_cfg_pkg::count_t                     count
);
  import tracker_cfg_pkg::*;

  // Number of allocation transfers in this cycle
  count_t alloc_total;

  always_comb begin
    alloc_total = '0;
    for (int i = 0; i < num_alloc_ports; i++) begin
      alloc_total = alloc_total + count_t'(alloc_fire[i]);
    end
  end

  // Staged tags still count as free, only requester-held tags are subtracted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= count_t'(num_entries);
    end else begin
      count <= count + count_t'(dealloc_fire) - alloc_total;
    end
  end

endmodule

`default_nettype wire

/* rtl/context_table.sv */
`default_nettype none

module context_table (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic [tracker_cfg_pkg::num_alloc_ports-1:0]                  wr_en,
  input  tracker_cfg_pkg::tag_t [tracker_cfg_pkg::num_alloc_ports-1:0] wr_tag,
  input  tracker_msg_pkg::ctx_t [tracker_cfg_pkg::num_alloc_ports-1:0] wr_ctx,
  input  tracker_cfg_pkg::tag_t                                        rd_tag,
  output tracker_msg_pkg::ctx_t                                        rd_ctx
);
  import tracker_cfg_pkg::*;
  import tracker_msg_pkg::*;

  // One context word per tag
  ctx_t table_q [num_entries];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_entries; i++) begin
        table_q[i] <= '0;
      end
    end else begin
      // The freelist never gives one tag to two ports, so the writes
      // always land in different rows
      for (int p = 0; p < num_alloc_ports; p++) begin
        if (wr_en[p]) begin
          table_q[wr_tag[p]] <= wr_ctx[p];
        end
      end
    end
  end

  // Read is combinational so the response can be pushed in the request cycle
  assign rd_ctx = table_q[rd_tag];

endmodule

`default_nettype wire

/* rtl/tag_tracker_top.sv */
`default_nettype none

module tag_tracker_top (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  output logic [tracker_cfg_pkg::num_alloc_ports-1:0]                  alloc_valid,
  input  logic [tracker_cfg_pkg::num_alloc_ports-1:0]                  alloc_ready,
  output tracker_cfg_pkg::tag_t [tracker_cfg_pkg::num_alloc_ports-1:0] alloc_tag,
  input  tracker_msg_pkg::ctx_t [tracker_cfg_pkg::num_alloc_ports-1:0] alloc_ctx,
  input  logic                                                         cpl_req_valid,
  output logic                                                         cpl_req_ready,
  input  tracker_msg_pkg::cpl_req_t                                    cpl_req,
  output logic                                                         cpl_rsp_valid,
  input  logic                                                         cpl_rsp_ready,
  output tracker_msg_pkg::cpl_rsp_t                                    cpl_rsp,
  output tracker_cfg_pkg::count_t                                      free_count
);
  import tracker_cfg_pkg::*;
  import tracker_msg_pkg::*;

  logic [num_alloc_ports-1:0] alloc_fire;
  logic     cpl_fire;
  ctx_t     rd_ctx;
  cpl_rsp_t rsp_push;

  // A tag leaves staging and reaches the requester on this transfer
  assign alloc_fire = alloc_valid & alloc_ready;

  // Completion is taken only when the output stage has room
  assign cpl_fire = cpl_req_valid & cpl_req_ready;

  tag_freelist u_freelist (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_ready   (alloc_ready),
    .alloc_tag     (alloc_tag),
    .dealloc_valid (cpl_fire),
    .dealloc_tag   (cpl_req.tag)
  );

  free_count u_free_count (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_fire   (alloc_fire),
    .dealloc_fire (cpl_fire),
    .count        (free_count)
  );

  // Context is captured at the allocation transfer under the granted tag
  context_table u_ctx_table (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (alloc_fire),
    .wr_tag (alloc_tag),
    .wr_ctx (alloc_ctx),
    .rd_tag (cpl_req.tag),
    .rd_ctx (rd_ctx)
  );

  // Response pairs the returned tag with the context it was issued with
  assign rsp_push = '{tag: cpl_req.tag, ctx: rd_ctx};

  // Output stage push_ready doubles as the completion request ready
  flow_stage_reg #(
    .payload_t (cpl_rsp_t)
  ) cpl_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (cpl_req_valid),
    .push_ready (cpl_req_ready),
    .push_data  (rsp_push),
    .pop_valid  (cpl_rsp_valid),
    .pop_ready  (cpl_rsp_ready),
    .pop_data   (cpl_rsp)
  );

endmodule

`default_nettype wire

/* bench/tag_tracker_tb.sv */
`default_nettype none

module tag_tracker_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tracker_cfg_pkg::*;
  import tracker_msg_pkg::*;

  logic clk;
  logic rst_n;
  logic [num_alloc_ports-1:0] alloc_valid;
  logic [num_alloc_ports-1:0] alloc_ready;
  tag_t [num_alloc_ports-1:0] alloc_tag;
  ctx_t [num_alloc_ports-1:0] alloc_ctx;
  logic     cpl_req_valid;
  logic     cpl_req_ready;
  cpl_req_t cpl_req;
  logic     cpl_rsp_valid;
  logic     cpl_rsp_ready;
  cpl_rsp_t cpl_rsp;
  count_t   free_count;

  int mismatches;
  int timeouts;
  int other_errors;
  // Cycles left before the response side is ready again
  int stall_left;
  // Completions taken while the response side was held off
  int stalled_accepts;
  // Responses still owed by the DUT, oldest first
  tag_t exp_tag_q[$];
  ctx_t exp_ctx_q[$];

  initial clk = 1'b0;
  always #10 clk = ~clk;

  tag_tracker_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .alloc_valid   (alloc_valid),
    .alloc_ready   (alloc_ready),
    .alloc_tag     (alloc_tag),
    .alloc_ctx     (alloc_ctx),
    .cpl_req_valid (cpl_req_valid),
    .cpl_req_ready (cpl_req_ready),
    .cpl_req       (cpl_req),
    .cpl_rsp_valid (cpl_rsp_valid),
    .cpl_rsp_ready (cpl_rsp_ready),
    .cpl_rsp       (cpl_rsp),
    .free_count    (free_count)
  );

  task automatic check_tag(input string name, input tag_t exp_val, input tag_t act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: expected tag %0d, actual %0d", name, exp_val, act_val);
      mismatches++;
    end
  endtask

  task automatic check_ctx(input string name, input ctx_t exp_val, input ctx_t act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: expected ctx %h, actual %h", name, exp_val.data, act_val.data);
      mismatches++;
    end
  endtask

  task automatic check_count(input string name, input count_t exp_val, input count_t act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: expected count %0d, actual %0d", name, exp_val, act_val);
      mismatches++;
    end
  endtask

  // One clock step, taken from one falling edge to the next
  task automatic tick();
    // Valid and ready both high here means the response leaves on the next rising edge
    if (cpl_rsp_valid && cpl_rsp_ready) begin
      if (exp_tag_q.size() == 0) begin
        $display("Response for tag %0d came out with no request outstanding", cpl_rsp.tag);
        other_errors++;
      end else begin
        check_tag("completion response", exp_tag_q.pop_front(), cpl_rsp.tag);
        check_ctx("completion response", exp_ctx_q.pop_front(), cpl_rsp.ctx);
      end
    end
    @(negedge clk);
    if (stall_left > 0) begin
      stall_left--;
      if (stall_left == 0) begin
        cpl_rsp_ready = 1'b1;
        stalled_accepts = 0;
      end
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = $urandom % 4;
    repeat (gap) tick();
  endtask

  // Takes the staged tag on one port and hands over the context for it
  task automatic take_tag(input string name, input int port, input ctx_t ctx,
                          input tag_t exp_tag);
    int cycles;
    tag_t got;
    cycles = 0;
    alloc_ready[port] = 1'b1;
    alloc_ctx[port] = ctx;
    while (!alloc_valid[port] && cycles < 200) begin
      tick();
      cycles++;
    end
    if (!alloc_valid[port]) begin
      $display("%s: port %0d offered no tag within 200 cycles", name, port);
      timeouts++;
      alloc_ready[port] = 1'b0;
    end else begin
      // Valid and ready are both stable now, so the transfer is on the next rising edge
      got = alloc_tag[port];
      tick();
      alloc_ready[port] = 1'b0;
      check_tag(name, exp_tag, got);
    end
  endtask

  task automatic return_tag(input string name, input tag_t ret_tag, input ctx_t exp_ctx);
    int cycles;
    cycles = 0;
    cpl_req_valid = 1'b1;
    cpl_req.tag = ret_tag;
    while (!cpl_req_ready && cycles < 200) begin
      tick();
      cycles++;
    end
    if (!cpl_req_ready) begin
      $display("%s: request for tag %0d not accepted within 200 cycles", name, ret_tag);
      timeouts++;
      cpl_req_valid = 1'b0;
    end else begin
      // The output stage is two deep, so a third stalled request has to wait
      if (!cpl_rsp_ready) begin
        stalled_accepts++;
        if (stalled_accepts > 2) begin
          $display("%s: more than two requests accepted while responses were held", name);
          other_errors++;
        end
      end
      exp_tag_q.push_back(ret_tag);
      exp_ctx_q.push_back(exp_ctx);
      tick();
      cpl_req_valid = 1'b0;
      // An otherwise empty stage shows the response one cycle after the request
      if (exp_tag_q.size() == 1 && !cpl_rsp_valid) begin
        $display("%s: no response one cycle after the request", name);
        other_errors++;
      end
    end
  endtask

  task automatic stall_responses(input int cycles);
    if (cycles > 0) begin
      cpl_rsp_ready = 1'b0;
      stall_left = cycles;
      stalled_accepts = 0;
    end
  endtask

  task automatic drain_responses();
    int cycles;
    cycles = 0;
    while (exp_tag_q.size() != 0 && cycles < 200) begin
      tick();
      cycles++;
    end
    if (exp_tag_q.size() != 0) begin
      $display("%0d completion responses never came out", exp_tag_q.size());
      timeouts++;
    end
  endtask

  initial begin
    int fd;
    int op_no;
    int a;
    int c;
    logic [15:0] b;
    ctx_t ctx_val;
    string op;
    string rest;
    string name;

    void'($urandom(32'heb47));
    mismatches = 0;
    timeouts = 0;
    other_errors = 0;
    stall_left = 0;
    stalled_accepts = 0;
    op_no = 0;
    rst_n = 1'b0;
    alloc_ready = '0;
    alloc_ctx = '0;
    cpl_req_valid = 1'b0;
    cpl_req = '0;
    cpl_rsp_ready = 1'b1;

    repeat (2) tick();
    rst_n = 1'b1;
    // Outputs still hold their reset values in the first cycle after release
    if (alloc_valid != '0 || cpl_rsp_valid || cpl_req_ready) begin
      $display("Handshake outputs were not low in the first cycle after reset");
      other_errors++;
    end

    fd = $fopen("bench/tag_tracker_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file bench/tag_tracker_vectors.txt");
      other_errors++;
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.getc(0) == "#") begin
          void'($fgets(rest, fd));
        end else begin
          op_no++;
          idle_gap();
          if (op == "alloc") begin
            void'($fscanf(fd, "%d %h %d", a, b, c));
            ctx_val.data = b;
            name = $sformatf("op %0d alloc on port %0d", op_no, a);
            take_tag(name, a, ctx_val, tag_t'(c));
          end else if (op == "complete") begin
            void'($fscanf(fd, "%d %h", a, b));
            ctx_val.data = b;
            name = $sformatf("op %0d complete tag %0d", op_no, a);
            return_tag(name, tag_t'(a), ctx_val);
          end else if (op == "count") begin
            void'($fscanf(fd, "%d", a));
            name = $sformatf("op %0d free count", op_no);
            check_count(name, count_t'(a), free_count);
            // With every tag held by a requester nothing can be staged
            if (a == 0 && alloc_valid != '0) begin
              $display("%s: a port still offers a tag with none free", name);
              other_errors++;
            end
          end else if (op == "stall") begin
            void'($fscanf(fd, "%d", a));
            stall_responses(a);
          end else begin
            $display("Unknown operation %s in the vector file", op);
            other_errors++;
          end
        end
      end
      $fclose(fd);
    end

    drain_responses();
    $display("Error counts: %0d mismatches, %0d timeouts, %0d other errors",
             mismatches, timeouts, other_errors);
    if (mismatches + timeouts + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tag_tracker_vectors.txt */
# alloc port ctx_hex expected_tag | complete tag expected_ctx_hex
# count expected_free_count | stall cycles_with_response_ready_low
count 8
alloc 0 a000 0
alloc 1 a101 1
count 6
alloc 0 a202 2
alloc 1 a303 3
alloc 0 a404 4
alloc 1 a505 5
alloc 0 a606 6
alloc 1 a707 7
count 0
complete 3 a303
count 1
alloc 0 b003 3
complete 6 a606
complete 2 a202
complete 0 a000
count 3
alloc 1 b200 0
alloc 0 b306 6
alloc 0 b402 2
count 0
stall 30
complete 4 a404
complete 1 a101
complete 7 a707
count 3
alloc 0 c004 4
alloc 0 c001 1
alloc 1 c007 7
count 0
complete 4 c004
complete 7 c007
count 2

/* verilog.f */
rtl/tracker_cfg_pkg.sv
rtl/tracker_msg_pkg.sv
rtl/first_free_picker.sv
rtl/flow_stage_reg.sv
rtl/tag_freelist.sv
rtl/free_count.sv
rtl/context_table.sv
rtl/tag_tracker_top.sv
bench/tag_tracker_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the tag tracker testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module tag_tracker_tb -f verilog.f -o tag_tracker_sim \
  > sim.log 2>&1 \
  && ./obj_dir/tag_tracker_sim >> sim.log 2>&1 \
  || echo "Build or simulation did not complete, see sim.log"
grep -q "^Verification passed$" sim.log && echo "Simulation PASSED" && exit 0 \
  || { echo "Simulation FAILED, see sim.log"; exit 1; }
